//--- src.f
+incdir+tests
verilog/mmc5_pkg.sv
verilog/mmc5_regs.sv
verilog/mmc5_scanline.sv
verilog/mmc5_prg_map.sv
verilog/mmc5_chr_map.sv
verilog/mmc5_cpu_read.sv
verilog/mmc5_top.sv
tests/tb_mmc5.sv

//--- tests/mmc5_tests.svh
// MMC5 CPU and PPU bus tasks, expected address models and directed tests
`ifndef MMC5_TESTS_SVH
`define MMC5_TESTS_SVH

	// One M2 strobe carrying a write
	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		cpu_ce    <= 1'b1;
		cpu_wr    <= 1'b1;
		cpu_rd    <= 1'b0;
		cpu_addr  <= addr;
		cpu_wdata <= data;
		@(posedge clk);
		cpu_ce <= 1'b0;
		cpu_wr <= 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data,
	                        output logic valid);
		@(posedge clk);
		cpu_ce   <= 1'b1;
		cpu_wr   <= 1'b0;
		cpu_rd   <= 1'b1;
		cpu_addr <= addr;
		@(negedge clk);
		data  = cpu_rdata;
		valid = cpu_rdata_valid;
		@(posedge clk);
		cpu_ce <= 1'b0;
		cpu_rd <= 1'b0;
	endtask

	// Address on the bus with M2 low, sampled at the falling edge
	task automatic bus_peek(input logic [15:0] addr, input logic wr);
		@(posedge clk);
		cpu_addr <= addr;
		cpu_wr   <= wr;
		cpu_rd   <= !wr;
		@(negedge clk);
	endtask

	task automatic ppu_peek(input logic [13:0] addr);
		@(posedge clk);
		ppu_addr <= addr;
		@(negedge clk);
	endtask

	task automatic ppu_fetch(input logic [13:0] addr);
		@(posedge clk);
		ppu_addr <= addr;
		ppu_rd   <= 1'b1;
		@(posedge clk);
		ppu_rd <= 1'b0;
	endtask

	task automatic render_line();
		repeat (4) ppu_fetch(14'h23C1); // Same nametable byte four times
		ppu_fetch(14'h0150);
	endtask

	task automatic wait_irq(input logic level);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (irq !== level && cycles < 4);
		if (irq !== level) begin
			$display("irq_o did not reach %0b within 4 cycles", level);
			abort_run();
		end
	endtask

	// PRG model from the mode table, sizes counted in 8 kB pages
	function automatic logic [21:0] expect_prg(input logic [1:0] mode, input logic [15:0] addr);
		int         reg_idx;
		int         size;
		logic       rom;
		logic [7:0] bank;
		logic [1:0] slot;
		slot = addr[14:13];
		if (!addr[15])
			return {mmc5_pkg::PRG_RAM_PREFIX, ram_bank_exp, addr[12:0]};
		case (mode)
			2'd0: begin
				reg_idx = 3;
				size    = 4;
				rom     = 1'b1;
			end
			2'd1: begin
				reg_idx = slot[1] ? 3 : 1;
				size    = 2;
				rom     = slot[1];
			end
			2'd2: begin
				reg_idx = slot[1] ? int'(slot) : 1;
				size    = slot[1] ? 1 : 2;
				rom     = (slot == 2'd3);
			end
			default: begin
				reg_idx = slot;
				size    = 1;
				rom     = (slot == 2'd3);
			end
		endcase
		bank = 8'((prg_exp[reg_idx] & ~(size - 1)) | (slot & (size - 1)));
		if (rom)
			bank[7] = 1'b1;
		if (bank[7])
			return {mmc5_pkg::PRG_ROM_PREFIX, bank[6:0], addr[12:0]};
		return {mmc5_pkg::PRG_RAM_PREFIX, bank[2:0], addr[12:0]};
	endfunction

	// CHR model, span is the number of 1 kB pages per bank
	function automatic logic [21:0] expect_chr(input logic [1:0] mode, input logic [13:0] addr);
		int         span;
		int         idx;
		logic [9:0] page;
		span = 8 >> mode;
		idx  = addr[12:10] | (span - 1);
		page = 10'(chr_exp[idx] * span + (addr[12:10] & (span - 1)));
		return {mmc5_pkg::CHR_PREFIX, page, addr[9:0]};
	endfunction

	task automatic prg_mode_sweep();
		logic [15:0] addr;
		for (int mode = 0; mode < 4; mode++) begin
			cpu_write(mmc5_pkg::REG_PRG_MODE, 8'(mode));
			for (int i = 0; i < 4; i++) begin
				prg_exp[i] = 8'($urandom);
				if (mode == 3 && i == 0)
					prg_exp[i][7] = 1'b0; // RAM bank at $8000
				cpu_write(mmc5_pkg::REG_PRG_BANK0 + 16'(i), prg_exp[i]);
			end
			ram_bank_exp = 3'($urandom);
			cpu_write(mmc5_pkg::REG_PRG_RAM_BANK, {5'd0, ram_bank_exp});
			for (int slot = 0; slot < 5; slot++) begin
				addr = 16'h6000 + 16'(slot) * 16'h2000 + 16'($urandom % 8192);
				bus_peek(addr, 1'b0);
				compare(prg_addr, expect_prg(2'(mode), addr),
				        $sformatf("prg_addr mode %0d at %h", mode, addr));
			end
		end
		bus_peek(16'h8000, 1'b0);
		compare(prg_addr[21:16], mmc5_pkg::PRG_RAM_PREFIX, "RAM prefix for bank0 at $8000");
	endtask

	task automatic prg_permission_walk();
		bus_peek(16'h6000, 1'b0);
		compare(prg_allow, 1'b1, "read at $6000");
		bus_peek(16'h5000, 1'b0);
		compare(prg_allow, 1'b0, "read at $5000");
		bus_peek(16'h6000, 1'b1);
		compare(prg_allow, 1'b0, "RAM write without keys");
		cpu_write(mmc5_pkg::REG_PROTECT1, {6'd0, mmc5_pkg::PROTECT1_KEY});
		bus_peek(16'h6000, 1'b1);
		compare(prg_allow, 1'b0, "RAM write with one key");
		cpu_write(mmc5_pkg::REG_PROTECT2, {6'd0, mmc5_pkg::PROTECT2_KEY});
		bus_peek(16'h6000, 1'b1);
		compare(prg_allow, 1'b1, "RAM write with both keys");
		bus_peek(16'hE000, 1'b1);
		compare(prg_allow, 1'b0, "ROM write");
	endtask

	task automatic chr_mode_sweep();
		logic [1:0]  upper;
		logic [13:0] addr;
		for (int mode = 0; mode < 4; mode++) begin
			cpu_write(mmc5_pkg::REG_CHR_MODE, 8'(mode));
			for (int i = 0; i < 8; i++) begin
				if (i % 4 == 0) begin
					upper = 2'($urandom); // New upper bits halfway through
					cpu_write(mmc5_pkg::REG_CHR_UPPER, {6'd0, upper});
				end
				chr_exp[i] = {upper, 8'($urandom)};
				cpu_write(mmc5_pkg::REG_CHR_BANK0 + 16'(i), chr_exp[i][7:0]);
			end
			for (int i = 0; i < 8; i++) begin
				addr = 14'(i * 1024 + $urandom % 1024);
				ppu_peek(addr);
				compare(chr_addr, expect_chr(2'(mode), addr),
				        $sformatf("chr_addr mode %0d at %h", mode, addr));
			end
		end
	endtask

	task automatic mirroring_quadrants();
		logic [7:0]  pattern;
		logic [13:0] addr;
		for (int n = 0; n < 3; n++) begin
			pattern = (n == 0) ? 8'hE4 : 8'($urandom);
			cpu_write(mmc5_pkg::REG_MIRROR, pattern);
			for (int q = 0; q < 4; q++) begin
				addr = 14'(16'h2000 + q * 1024 + 16'h3C5);
				ppu_peek(addr);
				compare(vram_a10, pattern[2*q], $sformatf("vram_a10 quadrant %0d", q));
				compare(vram_ce, !pattern[2*q+1], $sformatf("vram_ce quadrant %0d", q));
			end
		end
		ppu_peek(14'h0800);
		compare(vram_ce, 1'b0, "vram_ce on a pattern fetch");
	endtask

	task automatic multiplier_products();
		logic [7:0]  a;
		logic [7:0]  b;
		logic [15:0] product;
		logic [7:0]  data;
		logic        valid;
		repeat (4) begin
			a       = 8'($urandom);
			b       = 8'($urandom);
			product = 16'(a) * 16'(b);
			cpu_write(mmc5_pkg::REG_MUL_A, a);
			cpu_write(mmc5_pkg::REG_MUL_B, b);
			cpu_read(mmc5_pkg::REG_MUL_A, data, valid);
			compare(data, product[7:0], $sformatf("product low byte of %0d*%0d", a, b));
			compare(valid, 1'b1, "valid at $5205");
			cpu_read(mmc5_pkg::REG_MUL_B, data, valid);
			compare(data, product[15:8], $sformatf("product high byte of %0d*%0d", a, b));
			compare(valid, 1'b1, "valid at $5206");
		end
		cpu_read(16'h5207, data, valid);
		compare(valid, 1'b0, "valid at $5207");
		compare(data, 8'hFF, "open bus data at $5207");
	endtask

	task automatic scanline_irq_frame();
		logic [7:0] line;
		logic [7:0] data;
		logic       valid;
		line = 8'd2 + 8'($urandom % 4);
		cpu_write(mmc5_pkg::REG_IRQ_LINE, line);
		cpu_write(mmc5_pkg::REG_IRQ_STATUS, 8'h80);
		render_line();
		bus_peek(mmc5_pkg::REG_IRQ_STATUS, 1'b0);
		compare(cpu_rdata, 8'h7F, "status after the first line");
		repeat (line - 1) render_line();
		bus_peek(mmc5_pkg::REG_IRQ_STATUS, 1'b0);
		compare(irq, 1'b0, "irq_o before the IRQ line");
		render_line();
		wait_irq(1'b1);
		cpu_read(mmc5_pkg::REG_IRQ_STATUS, data, valid);
		compare(data, 8'hFF, "status with IRQ pending");
		bus_peek(mmc5_pkg::REG_IRQ_STATUS, 1'b0);
		compare(cpu_rdata, 8'hFF, "pending held until the next strobe");
		cpu_read(16'h8000, data, valid); // Next strobe acknowledges
		wait_irq(1'b0);
		bus_peek(mmc5_pkg::REG_IRQ_STATUS, 1'b0);
		compare(cpu_rdata, 8'h7F, "status after acknowledge");
		render_line();
		for (int k = 1; k <= 3; k++) begin
			cpu_read(16'h8000, data, valid);
			bus_peek(mmc5_pkg::REG_IRQ_STATUS, 1'b0);
			compare(cpu_rdata, (k < 3) ? 8'h7F : 8'h3F,
			        $sformatf("status after idle strobe %0d", k));
		end
	endtask

`endif

//--- tests/tb_mmc5.sv
// MMC5 testbench top with clock, reset, DUT, value check, watchdog and test sequence
module tb_mmc5;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD  = 100;
	localparam int NUM_TESTS   = 6;
	localparam int TEST_CYCLES = 400; // Cycle budget per directed test

	logic        clk;
	logic        arst_n;
	logic        cpu_ce;
	logic [15:0] cpu_addr;
	logic        cpu_wr;
	logic        cpu_rd;
	logic [7:0]  cpu_wdata;
	logic [13:0] ppu_addr;
	logic        ppu_rd;
	logic [7:0]  cpu_rdata;
	logic        cpu_rdata_valid;
	logic [21:0] prg_addr;
	logic        prg_allow;
	logic [21:0] chr_addr;
	logic        vram_a10;
	logic        vram_ce;
	logic        irq;
	logic [7:0]  prg_exp [4]; // Bank values as last written
	logic [2:0]  ram_bank_exp;
	logic [9:0]  chr_exp [8];
	int unsigned seed_val;

	mmc5_top u_dut (
		.clk(clk), .arst_n_i(arst_n), .cpu_ce_i(cpu_ce), .cpu_addr_i(cpu_addr),
		.cpu_wr_i(cpu_wr), .cpu_rd_i(cpu_rd), .cpu_wdata_i(cpu_wdata),
		.ppu_addr_i(ppu_addr), .ppu_rd_i(ppu_rd), .cpu_rdata_o(cpu_rdata),
		.cpu_rdata_valid_o(cpu_rdata_valid), .prg_addr_o(prg_addr), .prg_allow_o(prg_allow),
		.chr_addr_o(chr_addr), .vram_a10_o(vram_a10), .vram_ce_o(vram_ce), .irq_o(irq)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
	                       input string what);
		if (actual !== expected) begin
			$display("MISMATCH at %0d ns: %s got %0h expected %0h", $time, what, actual, expected);
			abort_run();
		end
	endtask

	`include "mmc5_tests.svh"

	initial begin
		#(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
		$display("Watchdog expired, the test sequence did not finish in time");
		abort_run();
	end

	initial begin
		seed_val  = $urandom(3);
		arst_n    = 1'b0;
		cpu_ce    = 1'b0;
		cpu_addr  = '0;
		cpu_wr    = 1'b0;
		cpu_rd    = 1'b0;
		cpu_wdata = '0;
		ppu_addr  = '0;
		ppu_rd    = 1'b0;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;

		// Power-on state
		bus_peek(16'h5000, 1'b0);
		compare(prg_allow, 1'b0, "prg_allow below $6000 after reset");
		compare(cpu_rdata_valid, 1'b0, "read valid after reset");
		compare(irq, 1'b0, "irq_o after reset");
		bus_peek(16'hE000, 1'b0);
		compare(prg_addr, {2'b00, 7'h7F, 13'h0}, "last ROM bank at $E000 after reset");
		bus_peek(16'hA000, 1'b0); // Only the 8 kB mode maps RAM bank 0 here
		compare(prg_addr, {mmc5_pkg::PRG_RAM_PREFIX, 3'd0, 13'h0}, "PRG mode 3 after reset");
		bus_peek(mmc5_pkg::REG_IRQ_STATUS, 1'b0);
		compare(cpu_rdata, 8'h3F, "status after reset");

		prg_mode_sweep();
		prg_permission_walk();
		chr_mode_sweep();
		mirroring_quadrants();
		multiplier_products();
		scanline_irq_frame();

		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- verilog/mmc5_top.sv
// MMC5 mapper core top level with register file, scanline detector, address maps and read mux
module mmc5_top (
	input  logic                            clk,
	input  logic                            arst_n_i,
	input  logic                            cpu_ce_i,    // M2 strobe
	input  logic [mmc5_pkg::CPU_AW-1:0]     cpu_addr_i,
	input  logic                            cpu_wr_i,
	input  logic                            cpu_rd_i,
	input  logic [mmc5_pkg::DW-1:0]         cpu_wdata_i,
	input  logic [mmc5_pkg::PPU_AW-1:0]     ppu_addr_i,
	input  logic                            ppu_rd_i,
	output logic [mmc5_pkg::DW-1:0]         cpu_rdata_o,
	output logic                            cpu_rdata_valid_o,
	output logic [mmc5_pkg::PRG_OUT_AW-1:0] prg_addr_o,
	output logic                            prg_allow_o,
	output logic [mmc5_pkg::CHR_OUT_AW-1:0] chr_addr_o,
	output logic                            vram_a10_o,
	output logic                            vram_ce_o,
	output logic                            irq_o
);

	logic [1:0]                      prg_mode;
	logic [1:0]                      chr_mode;
	logic                            prg_ram_we;
	logic [7:0]                      mirroring;
	logic [2:0]                      prg_ram_bank;
	logic [mmc5_pkg::PRG_BANK_W-1:0] prg_bank0, prg_bank1, prg_bank2, prg_bank3;
	logic [mmc5_pkg::CHR_BANK_W-1:0] chr_bank [mmc5_pkg::CHR_BANKS];
	logic [mmc5_pkg::DW-1:0]         irq_line;
	logic                            irq_enable;
	logic [mmc5_pkg::DW-1:0]         mul_a, mul_b;
	logic                            in_frame;
	logic                            irq_pending;

	mmc5_regs u_regs (
		.clk, .arst_n_i, .cpu_ce_i, .cpu_wr_i, .cpu_addr_i, .cpu_wdata_i,
		.prg_mode_o(prg_mode), .chr_mode_o(chr_mode), .prg_ram_we_o(prg_ram_we),
		.mirroring_o(mirroring), .prg_ram_bank_o(prg_ram_bank),
		.prg_bank0_o(prg_bank0), .prg_bank1_o(prg_bank1),
		.prg_bank2_o(prg_bank2), .prg_bank3_o(prg_bank3),
		.chr_bank_o(chr_bank), .irq_line_o(irq_line), .irq_enable_o(irq_enable),
		.mul_a_o(mul_a), .mul_b_o(mul_b)
	);

	mmc5_scanline u_scanline (
		.clk, .arst_n_i, .cpu_ce_i, .cpu_rd_i, .cpu_addr_i, .ppu_addr_i, .ppu_rd_i,
		.irq_line_i(irq_line), .in_frame_o(in_frame), .irq_pending_o(irq_pending)
	);

	mmc5_prg_map u_prg_map (
		.cpu_addr_i, .cpu_wr_i, .prg_mode_i(prg_mode), .prg_ram_bank_i(prg_ram_bank),
		.prg_bank0_i(prg_bank0), .prg_bank1_i(prg_bank1),
		.prg_bank2_i(prg_bank2), .prg_bank3_i(prg_bank3),
		.prg_ram_we_i(prg_ram_we), .prg_addr_o, .prg_allow_o
	);

	mmc5_chr_map u_chr_map (
		.ppu_addr_i, .chr_mode_i(chr_mode), .chr_bank_i(chr_bank),
		.mirroring_i(mirroring), .chr_addr_o, .vram_a10_o, .vram_ce_o
	);

	mmc5_cpu_read u_cpu_read (
		.cpu_addr_i, .mul_a_i(mul_a), .mul_b_i(mul_b), .in_frame_i(in_frame),
		.irq_pending_i(irq_pending), .cpu_rdata_o, .cpu_rdata_valid_o
	);

	// IRQ line registered so it cannot glitch
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i)
			irq_o <= 1'b0;
		else
			irq_o <= irq_pending && irq_enable;
	end

endmodule

//--- verilog/mmc5_cpu_read.sv
// MMC5 8x8 multiplier and CPU read data mux for status and product
module mmc5_cpu_read (
	input  logic [mmc5_pkg::CPU_AW-1:0] cpu_addr_i,
	input  logic [mmc5_pkg::DW-1:0]     mul_a_i,
	input  logic [mmc5_pkg::DW-1:0]     mul_b_i,
	input  logic                        in_frame_i,
	input  logic                        irq_pending_i,
	output logic [mmc5_pkg::DW-1:0]     cpu_rdata_o,
	output logic                        cpu_rdata_valid_o
);

	logic [2*mmc5_pkg::DW-1:0] product;

	assign product = mul_a_i * mul_b_i; // Unsigned

	always_comb begin
		cpu_rdata_valid_o = 1'b1;
		case (cpu_addr_i)
			mmc5_pkg::REG_IRQ_STATUS: begin
				cpu_rdata_o = {irq_pending_i, in_frame_i, 6'h3F};
			end
			mmc5_pkg::REG_MUL_A: cpu_rdata_o = product[7:0];
			mmc5_pkg::REG_MUL_B: cpu_rdata_o = product[15:8];
			default: begin
				// Open bus, the mapper leaves the data lines alone
				cpu_rdata_o       = 8'hFF;
				cpu_rdata_valid_o = 1'b0;
			end
		endcase
	end

endmodule

//--- verilog/mmc5_chr_map.sv
// MMC5 CHR bank translation and internal nametable mirroring lines
module mmc5_chr_map (
	input  logic [mmc5_pkg::PPU_AW-1:0]     ppu_addr_i,
	input  logic [1:0]                      chr_mode_i,
	input  logic [mmc5_pkg::CHR_BANK_W-1:0] chr_bank_i [mmc5_pkg::CHR_BANKS],
	input  logic [7:0]                      mirroring_i,
	output logic [mmc5_pkg::CHR_OUT_AW-1:0] chr_addr_o,
	output logic                            vram_a10_o,
	output logic                            vram_ce_o
);

	logic [mmc5_pkg::CHR_BANK_W-1:0] chr_sel; // 1 kB page number
	logic [mmc5_pkg::CHR_BANK_W-1:0] bank_2k;
	logic [mmc5_pkg::CHR_BANK_W-1:0] bank_4k;
	logic [1:0]                      mirr_bits;

	// Wider banks always take the odd registers
	assign bank_2k = chr_bank_i[{ppu_addr_i[12:11], 1'b1}];
	assign bank_4k = ppu_addr_i[12] ? chr_bank_i[7] : chr_bank_i[3];

	always_comb begin
		case (chr_mode_i)
			mmc5_pkg::CHR_MODE_8K: chr_sel = {chr_bank_i[7][6:0], ppu_addr_i[12:10]};
			mmc5_pkg::CHR_MODE_4K: chr_sel = {bank_4k[7:0], ppu_addr_i[11:10]};
			mmc5_pkg::CHR_MODE_2K: chr_sel = {bank_2k[8:0], ppu_addr_i[10]};
			default:               chr_sel = chr_bank_i[ppu_addr_i[12:10]];
		endcase
	end

	assign chr_addr_o = {mmc5_pkg::CHR_PREFIX, chr_sel, ppu_addr_i[9:0]};

	// One 2-bit field per nametable quadrant
	assign mirr_bits = mirroring_i[{ppu_addr_i[11:10], 1'b0} +: 2];

	// Codes 0 and 1 pick CIRAM page A or B
	assign vram_a10_o = mirr_bits[0];

	// Codes 2 and 3 only release the internal VRAM
	assign vram_ce_o = ppu_addr_i[13] && !mirr_bits[1];

endmodule

//--- verilog/mmc5_prg_map.sv
// MMC5 PRG bank translation and PRG access permission
module mmc5_prg_map (
	input  logic [mmc5_pkg::CPU_AW-1:0]     cpu_addr_i,
	input  logic                            cpu_wr_i,
	input  logic [1:0]                      prg_mode_i,
	input  logic [2:0]                      prg_ram_bank_i,
	input  logic [mmc5_pkg::PRG_BANK_W-1:0] prg_bank0_i,
	input  logic [mmc5_pkg::PRG_BANK_W-1:0] prg_bank1_i,
	input  logic [mmc5_pkg::PRG_BANK_W-1:0] prg_bank2_i,
	input  logic [mmc5_pkg::PRG_BANK_W-1:0] prg_bank3_i,
	input  logic                            prg_ram_we_i,
	output logic [mmc5_pkg::PRG_OUT_AW-1:0] prg_addr_o,
	output logic                            prg_allow_o
);

	logic [7:0] prg_sel; // Bit 7 set means ROM

	always_comb begin
		prg_sel = {5'd0, prg_ram_bank_i}; // $6000-$7FFF window
		if (cpu_addr_i[15]) begin
			case (prg_mode_i)
				mmc5_pkg::PRG_MODE_32K: prg_sel = {1'b1, prg_bank3_i[6:2], cpu_addr_i[14:13]};
				mmc5_pkg::PRG_MODE_16K: begin
					if (cpu_addr_i[14])
						prg_sel = {1'b1, prg_bank3_i[6:1], cpu_addr_i[13]};
					else
						prg_sel = {prg_bank1_i[7:1], cpu_addr_i[13]};
				end
				mmc5_pkg::PRG_MODE_16K_8K: begin
					case (cpu_addr_i[14:13])
						2'b10:   prg_sel = prg_bank2_i;
						2'b11:   prg_sel = {1'b1, prg_bank3_i[6:0]};
						default: prg_sel = {prg_bank1_i[7:1], cpu_addr_i[13]};
					endcase
				end
				default: begin
					case (cpu_addr_i[14:13])
						2'b00:   prg_sel = prg_bank0_i;
						2'b01:   prg_sel = prg_bank1_i;
						2'b10:   prg_sel = prg_bank2_i;
						default: prg_sel = {1'b1, prg_bank3_i[6:0]}; // $E000 is always ROM
					endcase
				end
			endcase
		end
	end

	assign prg_addr_o = {prg_sel[7] ? {mmc5_pkg::PRG_ROM_PREFIX, prg_sel[6:0]}
	                                : {mmc5_pkg::PRG_RAM_PREFIX, prg_sel[2:0]},
	                     cpu_addr_i[12:0]};

	// Writes only land in unprotected RAM
	assign prg_allow_o = (cpu_addr_i >= mmc5_pkg::PRG_RAM_START) &&
	                     (!cpu_wr_i || (!prg_sel[7] && prg_ram_we_i));

endmodule

//--- verilog/mmc5_scanline.sv
// MMC5 scanline detector with in-frame flag, scanline counter and IRQ pending
module mmc5_scanline (
	input  logic                        clk,
	input  logic                        arst_n_i,
	input  logic                        cpu_ce_i,
	input  logic                        cpu_rd_i,
	input  logic [mmc5_pkg::CPU_AW-1:0] cpu_addr_i,
	input  logic [mmc5_pkg::PPU_AW-1:0] ppu_addr_i,
	input  logic                        ppu_rd_i,
	input  logic [mmc5_pkg::DW-1:0]     irq_line_i,
	output logic                        in_frame_o,
	output logic                        irq_pending_o
);

	logic                        ppu_rd_q;
	logic [mmc5_pkg::PPU_AW-1:0] last_addr_q;
	logic [1:0]                  nt_cnt_q;
	logic [1:0]                  idle_cnt_q;
	logic [7:0]                  scanline_q;
	logic                        clear_req_q;
	logic [7:0]                  next_line;
	logic                        ppu_rd_rise;
	logic                        nt_match;
	logic                        line_event;
	logic                        status_read;
	logic                        leave;

	assign ppu_rd_rise = ppu_rd_i && !ppu_rd_q;
	assign next_line   = scanline_q + 8'd1;

	// Same nametable byte as the read before
	assign nt_match = (ppu_addr_i[13:12] == 2'b10) && (ppu_addr_i == last_addr_q);

	// Fires on the read that follows the run of matches
	assign line_event = ppu_rd_rise && (nt_cnt_q == mmc5_pkg::NT_REPEAT);

	assign status_read = cpu_ce_i && cpu_rd_i && (cpu_addr_i == mmc5_pkg::REG_IRQ_STATUS);

	assign leave = in_frame_o && (
		(line_event && scanline_q == mmc5_pkg::LAST_SCANLINE) ||
		(cpu_ce_i && !ppu_rd_i && idle_cnt_q == mmc5_pkg::IDLE_LIMIT) ||
		(cpu_ce_i && cpu_rd_i && {cpu_addr_i[15:1], 1'b0} == mmc5_pkg::NMI_VEC));

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ppu_rd_q      <= 1'b0;
			last_addr_q   <= '0;
			nt_cnt_q      <= '0;
			idle_cnt_q    <= '0;
			scanline_q    <= '0;
			clear_req_q   <= 1'b0;
			in_frame_o    <= 1'b0;
			irq_pending_o <= 1'b0;
		end else begin
			ppu_rd_q <= ppu_rd_i;

			if (ppu_rd_rise) begin
				last_addr_q <= ppu_addr_i;
				if (!nt_match)
					nt_cnt_q <= '0;
				else if (nt_cnt_q != mmc5_pkg::NT_REPEAT)
					nt_cnt_q <= nt_cnt_q + 2'd1;
			end

			if (line_event) begin
				if (!in_frame_o) begin
					in_frame_o <= 1'b1; // First line of the frame
					scanline_q <= '0;
				end else if (scanline_q != mmc5_pkg::LAST_SCANLINE) begin
					scanline_q <= next_line;
					if (next_line == irq_line_i)
						irq_pending_o <= 1'b1;
				end
			end

			// Idle M2 strobes without PPU activity
			if (ppu_rd_i)
				idle_cnt_q <= '0;
			else if (cpu_ce_i && in_frame_o)
				idle_cnt_q <= idle_cnt_q + 2'd1;

			if (cpu_ce_i) begin
				clear_req_q <= status_read;
				if (clear_req_q)
					irq_pending_o <= 1'b0; // Acknowledge one strobe after the $5204 read
			end

			if (leave) begin
				in_frame_o    <= 1'b0;
				irq_pending_o <= 1'b0;
				nt_cnt_q      <= '0;
				idle_cnt_q    <= '0;
				scanline_q    <= '0;
			end
		end
	end

	a_pending_in_frame: assert property (
		@(posedge clk) disable iff (!arst_n_i) irq_pending_o |-> in_frame_o
	);

endmodule

//--- verilog/mmc5_regs.sv
// MMC5 configuration register file written from the CPU register page
module mmc5_regs (
	input  logic                                 clk,
	input  logic                                 arst_n_i,
	input  logic                                 cpu_ce_i,
	input  logic                                 cpu_wr_i,
	input  logic [mmc5_pkg::CPU_AW-1:0]          cpu_addr_i,
	input  logic [mmc5_pkg::DW-1:0]              cpu_wdata_i,
	output logic [1:0]                           prg_mode_o,
	output logic [1:0]                           chr_mode_o,
	output logic                                 prg_ram_we_o,
	output logic [7:0]                           mirroring_o,
	output logic [2:0]                           prg_ram_bank_o,
	output logic [mmc5_pkg::PRG_BANK_W-1:0]      prg_bank0_o,
	output logic [mmc5_pkg::PRG_BANK_W-1:0]      prg_bank1_o,
	output logic [mmc5_pkg::PRG_BANK_W-1:0]      prg_bank2_o,
	output logic [mmc5_pkg::PRG_BANK_W-1:0]      prg_bank3_o,
	output logic [mmc5_pkg::CHR_BANK_W-1:0]      chr_bank_o [mmc5_pkg::CHR_BANKS],
	output logic [mmc5_pkg::DW-1:0]              irq_line_o,
	output logic                                 irq_enable_o,
	output logic [mmc5_pkg::DW-1:0]              mul_a_o,
	output logic [mmc5_pkg::DW-1:0]              mul_b_o
);

	logic [mmc5_pkg::PRG_BANK_W-1:0] prg_bank_q [4];
	logic [1:0] chr_upper_q;
	logic       protect1_q;
	logic       protect2_q;
	logic       reg_wr;
	logic       prg_bank_hit;
	logic       chr_bank_hit;

	assign reg_wr = cpu_ce_i && cpu_wr_i && (cpu_addr_i[15:10] == mmc5_pkg::REG_PAGE);

	// Bank register groups decode on the low page bits only
	assign prg_bank_hit = (cpu_addr_i[9:2] == mmc5_pkg::REG_PRG_BANK0[9:2]);
	assign chr_bank_hit = (cpu_addr_i[9:3] == mmc5_pkg::REG_CHR_BANK0[9:3]);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			prg_mode_o     <= mmc5_pkg::PRG_MODE_8K; // Power-on state
			chr_mode_o     <= '0;
			protect1_q     <= 1'b0;
			protect2_q     <= 1'b0;
			mirroring_o    <= '0;
			prg_ram_bank_o <= '0;
			prg_bank_q[0]  <= '0;
			prg_bank_q[1]  <= '0;
			prg_bank_q[2]  <= '0;
			prg_bank_q[3]  <= 8'h7F; // Last ROM bank at $E000
			chr_bank_o     <= '{default: '0};
			chr_upper_q    <= '0;
			irq_line_o     <= '0;
			irq_enable_o   <= 1'b0;
			mul_a_o        <= '0;
			mul_b_o        <= '0;
		end else if (reg_wr) begin
			if (prg_bank_hit) begin
				prg_bank_q[cpu_addr_i[1:0]] <= cpu_wdata_i;
			end else if (chr_bank_hit) begin
				// Upper bits come from $5130 as it stands now
				chr_bank_o[cpu_addr_i[2:0]] <= {chr_upper_q, cpu_wdata_i};
			end else begin
				case (cpu_addr_i[9:0])
					mmc5_pkg::REG_PRG_MODE[9:0]:     prg_mode_o <= cpu_wdata_i[1:0];
					mmc5_pkg::REG_CHR_MODE[9:0]:     chr_mode_o <= cpu_wdata_i[1:0];
					mmc5_pkg::REG_PROTECT1[9:0]: begin
						protect1_q <= (cpu_wdata_i[1:0] == mmc5_pkg::PROTECT1_KEY);
					end
					mmc5_pkg::REG_PROTECT2[9:0]: begin
						protect2_q <= (cpu_wdata_i[1:0] == mmc5_pkg::PROTECT2_KEY);
					end
					mmc5_pkg::REG_MIRROR[9:0]:       mirroring_o <= cpu_wdata_i;
					mmc5_pkg::REG_PRG_RAM_BANK[9:0]: prg_ram_bank_o <= cpu_wdata_i[2:0];
					mmc5_pkg::REG_CHR_UPPER[9:0]:    chr_upper_q <= cpu_wdata_i[1:0];
					mmc5_pkg::REG_IRQ_LINE[9:0]:     irq_line_o <= cpu_wdata_i;
					mmc5_pkg::REG_IRQ_STATUS[9:0]:   irq_enable_o <= cpu_wdata_i[7];
					mmc5_pkg::REG_MUL_A[9:0]:        mul_a_o <= cpu_wdata_i;
					mmc5_pkg::REG_MUL_B[9:0]:        mul_b_o <= cpu_wdata_i;
					default: ; // Unmapped page addresses are ignored
				endcase
			end
		end
	end

	// RAM writes need both keys in place
	assign prg_ram_we_o = protect1_q && protect2_q;

	assign prg_bank0_o = prg_bank_q[0];
	assign prg_bank1_o = prg_bank_q[1];
	assign prg_bank2_o = prg_bank_q[2];
	assign prg_bank3_o = prg_bank_q[3];

	// PRG mode feeds the whole CPU address map
	a_prg_mode_known: assert property (
		@(posedge clk) disable iff (!arst_n_i) !$isunknown(prg_mode_o)
	);

endmodule

//--- verilog/mmc5_pkg.sv
// MMC5 package with bus widths, register addresses, protect keys, mode encodings and scanline limits
package mmc5_pkg;

	// Bus and field widths
	localparam int CPU_AW     = 16;
	localparam int PPU_AW     = 14;
	localparam int DW         = 8;
	localparam int PRG_OUT_AW = 22;
	localparam int CHR_OUT_AW = 22;
	localparam int PRG_BANK_W = 8;
	localparam int CHR_BANK_W = 10;
	localparam int CHR_BANKS  = 8;

	// CPU visible registers
	localparam logic [CPU_AW-1:0] REG_PRG_MODE     = 16'h5100;
	localparam logic [CPU_AW-1:0] REG_CHR_MODE     = 16'h5101;
	localparam logic [CPU_AW-1:0] REG_PROTECT1     = 16'h5102;
	localparam logic [CPU_AW-1:0] REG_PROTECT2     = 16'h5103;
	localparam logic [CPU_AW-1:0] REG_MIRROR       = 16'h5105;
	localparam logic [CPU_AW-1:0] REG_PRG_RAM_BANK = 16'h5113;
	localparam logic [CPU_AW-1:0] REG_PRG_BANK0    = 16'h5114; // Up to $5117
	localparam logic [CPU_AW-1:0] REG_CHR_BANK0    = 16'h5120; // Up to $5127
	localparam logic [CPU_AW-1:0] REG_CHR_UPPER    = 16'h5130;
	localparam logic [CPU_AW-1:0] REG_IRQ_LINE     = 16'h5203;
	localparam logic [CPU_AW-1:0] REG_IRQ_STATUS   = 16'h5204; // Enable on write, status on read
	localparam logic [CPU_AW-1:0] REG_MUL_A        = 16'h5205;
	localparam logic [CPU_AW-1:0] REG_MUL_B        = 16'h5206;

	localparam logic [5:0]        REG_PAGE      = 6'b010100; // $5000-$53FF
	localparam logic [CPU_AW-1:0] NMI_VEC       = 16'hFFFA;
	localparam logic [CPU_AW-1:0] PRG_RAM_START = 16'h6000;

	localparam logic [1:0] PROTECT1_KEY = 2'd2;
	localparam logic [1:0] PROTECT2_KEY = 2'd1;

	// High bits of the translated addresses
	localparam logic [1:0] PRG_ROM_PREFIX = 2'b00;
	localparam logic [5:0] PRG_RAM_PREFIX = 6'b111100;
	localparam logic [1:0] CHR_PREFIX     = 2'b10;

	localparam logic [7:0] LAST_SCANLINE = 8'd239;
	localparam logic [1:0] NT_REPEAT     = 2'd3;
	localparam logic [1:0] IDLE_LIMIT    = 2'd2;

	// Banking modes
	localparam logic [1:0] PRG_MODE_32K    = 2'd0;
	localparam logic [1:0] PRG_MODE_16K    = 2'd1;
	localparam logic [1:0] PRG_MODE_16K_8K = 2'd2;
	localparam logic [1:0] PRG_MODE_8K     = 2'd3;
	localparam logic [1:0] CHR_MODE_8K     = 2'd0;
	localparam logic [1:0] CHR_MODE_4K     = 2'd1;
	localparam logic [1:0] CHR_MODE_2K     = 2'd2;
	localparam logic [1:0] CHR_MODE_1K     = 2'd3;

endpackage
